/* list.f */
hdl/mips_decode_pkg.sv
hdl/instr_if.sv
hdl/ctrl_if.sv
hdl/apb_instr_port.sv
hdl/control_unit.sv
hdl/decode_output_stage.sv
hdl/mips_decode_top.sv
tb/tb_mips_decode.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decode testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_mips_decode -f list.f \
    && ./obj_dir/Vtb_mips_decode > sim.log \
    || { echo "build or simulation error"; exit 1; }

cat sim.log
if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

/* tb/tb_mips_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mips_decode
    import mips_decode_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int N_XFER     = 44;     // apb transfers over all tests

    typedef struct packed {
        logic              jump, alu_src, branch, mem_to_reg;
        logic              reg_write, mem_read, mem_write, sign_flag;
        logic [1:0]        alu_op, width;
        logic [DATA_W-1:0] imm_ext;
        logic [NB_REG-1:0] rs, rt, dst_reg;
    } dec_res_t;

    logic              clk = 1'b0;
    logic              i_rst_n, i_psel, i_penable, i_pwrite;
    logic [ADDR_W-1:0] i_paddr;
    logic [DATA_W-1:0] i_pwdata;
    wire  [DATA_W-1:0] o_prdata, o_imm_ext;
    wire               o_pready, o_pslverr, o_valid, o_jump, o_alu_src, o_branch;
    wire               o_mem_to_reg, o_reg_write, o_mem_read, o_mem_write, o_sign_flag;
    wire  [1:0]        o_alu_op, o_width;
    wire  [NB_REG-1:0] o_rs, o_rt, o_dst_reg;
    dec_res_t          actual, exp_d1, exp_d2;

    string test_name;
    int    test_errs = 0, total_errs = 0, failed_tests = 0, tests_run = 0;
    int    seed, pulse_cnt;
    logic  acc_d1, acc_d2;          // accepted write, delayed to line up with o_valid

    logic [NB_OP-1:0] op_list [19] = '{OP_RTYPE, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDI,
        OP_SLTI, OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW};

    mips_decode_top UUT (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    assign actual = {o_jump, o_alu_src, o_branch, o_mem_to_reg, o_reg_write, o_mem_read,
                     o_mem_write, o_sign_flag, o_alu_op, o_width, o_imm_ext,
                     o_rs, o_rt, o_dst_reg};

    // expected result of one instruction word
    function automatic dec_res_t ref_decode(input logic [DATA_W-1:0] w);
        dec_res_t          r;
        logic [NB_OP-1:0]  op;
        logic [NB_OP-1:0]  fn;
        logic [NB_IMM-1:0] imm;
        logic              rtype, is_load, is_store, is_imm;
        op       = w[31:26];
        fn       = w[5:0];
        imm      = w[15:0];
        rtype    = (op == OP_RTYPE);
        is_load  = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU};
        is_store = op inside {OP_SB, OP_SH, OP_SW};
        is_imm   = op inside {OP_ADDI, OP_SLTI, OP_ORI, OP_XORI, OP_LUI};
        r.jump       = op inside {OP_J, OP_JAL} || (rtype && fn inside {FN_JR, FN_JALR});
        r.alu_src    = is_load || is_store || is_imm;
        r.branch     = op inside {OP_BEQ, OP_BNE};
        r.mem_to_reg = is_load;
        r.reg_write  = is_load || is_imm || op == OP_JAL || (rtype && fn != FN_JR);
        r.mem_read   = is_load;
        r.mem_write  = is_store;
        r.sign_flag  = op inside {OP_LBU, OP_LHU, OP_LWU, OP_LUI};
        r.alu_op     = rtype ? ALUOP_RTYPE :
                       (r.branch || op inside {OP_ORI, OP_XORI}) ? ALUOP_LOGIC :
                       (op == OP_SLTI) ? ALUOP_SLT : ALUOP_ADD;
        r.width      = op inside {OP_LB, OP_LBU, OP_SB} ? WIDTH_BYTE :
                       op inside {OP_LH, OP_LHU, OP_SH} ? WIDTH_HALF : WIDTH_WORD;
        if (op == OP_LUI)
            r.imm_ext = {imm, 16'h0000};
        else if (op inside {OP_ORI, OP_XORI})
            r.imm_ext = {16'h0000, imm};
        else
            r.imm_ext = {{16{imm[15]}}, imm};
        r.rs      = w[25:21];
        r.rt      = w[20:16];
        r.dst_reg = (op == OP_JAL) ? RA_REG : rtype ? w[15:11] : w[20:16];
        return r;
    endfunction

    always @(posedge clk) begin
        if (!i_rst_n) begin
            acc_d1    <= 1'b0;
            acc_d2    <= 1'b0;
            pulse_cnt <= 0;
        end else begin
            acc_d1 <= i_psel && i_penable && i_pwrite && (i_paddr == ADDR_INSTR);
            acc_d2 <= acc_d1;
            if (o_valid)
                pulse_cnt <= pulse_cnt + 1;
        end
        if (i_psel && i_penable && i_pwrite && (i_paddr == ADDR_INSTR))
            exp_d1 <= ref_decode(i_pwdata);
        if (acc_d1)
            exp_d2 <= exp_d1;
    end

    task automatic flag_error(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        test_errs++;
    endtask

    valid_timing: assert property (@(posedge clk) disable iff (!i_rst_n) o_valid == acc_d2)
        else flag_error("o_valid", 64'($sampled(acc_d2)), 64'($sampled(o_valid)));
    result_check: assert property (@(posedge clk) disable iff (!i_rst_n)
                                   o_valid |-> actual == exp_d2)
        else flag_error("result", 64'($sampled(exp_d2)), 64'($sampled(actual)));
    ready_check: assert property (@(posedge clk) disable iff (!i_rst_n) o_pready)
        else flag_error("o_pready", 64'h1, 64'($sampled(o_pready)));

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        repeat (2) @(negedge clk);          // let the last result checks land
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0)
            failed_tests++;
        $display("%-16s %0d errors", test_name, test_errs);
    endtask

    // setup then access; returns inside the access phase
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic slverr);
        @(posedge clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= wr;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge clk);
        i_penable <= 1'b1;
        @(negedge clk);
        rdata  = o_prdata;
        slverr = o_pslverr;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic decode_word(input logic [DATA_W-1:0] word);
        logic [DATA_W-1:0] rd;
        logic              err;
        int                n;
        apb_xfer(1'b1, ADDR_INSTR, word, rd, err);
        bus_idle();
        n = 0;
        while (!o_valid && n < 8) begin
            @(negedge clk);
            n++;
        end
        assert (o_valid) else begin
            $display("%s: no o_valid pulse after write of %h", test_name, word);
            test_errs++;
        end
    endtask

    // other fields random, bit 15 forced on request
    task automatic decode_op(input logic [NB_OP-1:0] op, input logic neg);
        logic [DATA_W-1:0] rnd;
        rnd = $random(seed);
        if (neg)
            rnd[15] = 1'b1;
        decode_word({op, rnd[25:0]});
    endtask

    initial begin
        logic [DATA_W-1:0] rd, rnd, last;
        logic [13:0]       ctl;
        logic              err;
        int                n, count0;
        seed      = 32'hf01e;
        i_rst_n   <= 1'b0;
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
        i_paddr   <= '0;
        i_pwdata  <= '0;
        repeat (3) @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);

        start_test("reset_state");
        ctl = {o_valid, o_pslverr, o_jump, o_alu_src, o_branch, o_mem_to_reg, o_reg_write,
               o_mem_read, o_mem_write, o_sign_flag, o_alu_op, o_width};
        assert (ctl == '0) else flag_error("outputs", 64'h0, 64'(ctl));
        apb_xfer(1'b0, ADDR_INSTR, '0, rd, err);
        bus_idle();
        assert (rd == '0) else flag_error("prdata", 64'h0, 64'(rd));
        end_test();

        start_test("opcode_table");
        foreach (op_list[i])
            decode_op(op_list[i], 1'b0);
        rnd = $random(seed);
        decode_word({OP_RTYPE, rnd[25:6], FN_JR});
        decode_word({OP_RTYPE, rnd[25:6], FN_JALR});
        end_test();

        start_test("imm_extend");
        decode_op(OP_ORI, 1'b1);
        decode_op(OP_XORI, 1'b1);
        decode_op(OP_ADDI, 1'b1);
        decode_op(OP_LB, 1'b1);
        decode_op(OP_LW, 1'b1);
        decode_op(OP_LUI, 1'b1);
        end_test();

        start_test("dest_reg");
        decode_op(OP_RTYPE, 1'b0);
        rnd = $random(seed);
        decode_word({OP_RTYPE, rnd[25:6], FN_JALR});
        decode_op(OP_SLTI, 1'b0);
        decode_op(OP_JAL, 1'b0);
        end_test();

        start_test("undef_and_slverr");
        decode_op(6'b111111, 1'b0);
        rnd  = $random(seed);
        last = {6'b011100, rnd[25:0]};         // not in the opcode table
        decode_word(last);
        apb_xfer(1'b1, 4'h4, ~last, rd, err);
        bus_idle();
        assert (err) else begin
            $display("%s: write to unmapped address gave no o_pslverr", test_name);
            test_errs++;
        end
        repeat (4) @(negedge clk);             // window for a stray o_valid
        apb_xfer(1'b0, ADDR_INSTR, '0, rd, err);
        bus_idle();
        assert (rd == last) else flag_error("prdata", 64'(last), 64'(rd));
        end_test();

        start_test("back_to_back");
        count0 = pulse_cnt;
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            apb_xfer(1'b1, ADDR_INSTR, {op_list[(i * 5) % 19], rnd[25:0]}, rd, err);
        end
        bus_idle();
        n = 0;
        while (pulse_cnt != count0 + 8 && n < 40) begin
            @(negedge clk);
            n++;
        end
        repeat (4) @(negedge clk);
        assert (pulse_cnt == count0 + 8)
            else flag_error("pulse count", 64'(count0 + 8), 64'(pulse_cnt));
        end_test();

        $display("%0d tests, %0d failing, %0d errors", tests_run, failed_tests, total_errs);
        if (total_errs == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (N_XFER * 4 + 100));
        $display("timeout: the tests did not finish in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/mips_decode_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_decode_top
    import mips_decode_pkg::*;
(
    input  wire                clk,
    input  wire                i_rst_n,

    input  wire                i_psel,
    input  wire                i_penable,
    input  wire                i_pwrite,
    input  wire [ADDR_W-1:0]   i_paddr,
    input  wire [DATA_W-1:0]   i_pwdata,
    output wire [DATA_W-1:0]   o_prdata,
    output wire                o_pready,
    output wire                o_pslverr,

    output wire                o_valid,         // decode result strobe
    output wire                o_jump,
    output wire                o_alu_src,
    output wire                o_branch,
    output wire                o_mem_to_reg,
    output wire                o_reg_write,
    output wire                o_mem_read,
    output wire                o_mem_write,
    output wire                o_sign_flag,
    output wire [1:0]          o_alu_op,
    output wire [1:0]          o_width,
    output wire [DATA_W-1:0]   o_imm_ext,
    output wire [NB_REG-1:0]   o_rs,
    output wire [NB_REG-1:0]   o_rt,
    output wire [NB_REG-1:0]   o_dst_reg
);

    instr_if u_instr_if ();
    ctrl_if  u_ctrl_if ();

    apb_instr_port u_apb_instr_port (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_instr   (u_instr_if.src)
    );

    control_unit u_control_unit (
        .i_instr (u_instr_if.dec),
        .o_ctrl  (u_ctrl_if.drv)
    );

    decode_output_stage u_decode_output_stage (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_instr      (u_instr_if.out),
        .i_ctrl       (u_ctrl_if.snk),
        .o_valid      (o_valid),
        .o_jump       (o_jump),
        .o_alu_src    (o_alu_src),
        .o_branch     (o_branch),
        .o_mem_to_reg (o_mem_to_reg),
        .o_reg_write  (o_reg_write),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_sign_flag  (o_sign_flag),
        .o_alu_op     (o_alu_op),
        .o_width      (o_width),
        .o_imm_ext    (o_imm_ext),
        .o_rs         (o_rs),
        .o_rt         (o_rt),
        .o_dst_reg    (o_dst_reg)
    );

endmodule

`default_nettype wire

/* hdl/decode_output_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_output_stage
    import mips_decode_pkg::*;
(
    input  wire                clk,
    input  wire                i_rst_n,

    instr_if.out               i_instr,
    ctrl_if.snk                i_ctrl,

    output logic               o_valid,
    output logic               o_jump,
    output logic               o_alu_src,
    output logic               o_branch,
    output logic               o_mem_to_reg,
    output logic               o_reg_write,
    output logic               o_mem_read,
    output logic               o_mem_write,
    output logic               o_sign_flag,
    output logic [1:0]         o_alu_op,
    output logic [1:0]         o_width,
    output logic [DATA_W-1:0]  o_imm_ext,
    output logic [NB_REG-1:0]  o_rs,
    output logic [NB_REG-1:0]  o_rt,
    output logic [NB_REG-1:0]  o_dst_reg
);

    logic [NB_IMM-1:0] imm;
    logic [DATA_W-1:0] imm_ext_d;
    logic [NB_REG-1:0] dst_reg_d;

    assign imm = i_instr.instr.i_fmt.imm16;

    always_comb begin
        if (i_ctrl.zero_ext && i_ctrl.sign_flag) begin
            imm_ext_d = {imm, {(DATA_W-NB_IMM){1'b0}}};           // lui
        end else if (i_ctrl.zero_ext) begin
            imm_ext_d = {{(DATA_W-NB_IMM){1'b0}}, imm};
        end else begin
            imm_ext_d = {{(DATA_W-NB_IMM){imm[NB_IMM-1]}}, imm};
        end
    end

    always_comb begin
        if (i_ctrl.link && !i_ctrl.reg_dst) begin
            dst_reg_d = RA_REG;                     // jal
        end else if (i_ctrl.reg_dst) begin
            dst_reg_d = i_instr.instr.r_fmt.rd;
        end else begin
            dst_reg_d = i_instr.instr.i_fmt.rt;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid      <= 1'b0;
            o_jump       <= 1'b0;
            o_alu_src    <= 1'b0;
            o_branch     <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_reg_write  <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_sign_flag  <= 1'b0;
            o_alu_op     <= 2'b00;
            o_width      <= 2'b00;
        end else begin
            o_valid <= i_instr.valid;               // single-cycle pulse
            if (i_instr.valid) begin
                o_jump       <= i_ctrl.jump;
                o_alu_src    <= i_ctrl.alu_src;
                o_branch     <= i_ctrl.branch;
                o_mem_to_reg <= i_ctrl.mem_to_reg;
                o_reg_write  <= i_ctrl.reg_write;
                o_mem_read   <= i_ctrl.mem_read;
                o_mem_write  <= i_ctrl.mem_write;
                o_sign_flag  <= i_ctrl.sign_flag;
                o_alu_op     <= i_ctrl.alu_op;
                o_width      <= i_ctrl.width;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_instr.valid) begin
            o_imm_ext <= imm_ext_d;
            o_rs      <= i_instr.instr.r_fmt.rs;
            o_rt      <= i_instr.instr.r_fmt.rt;
            o_dst_reg <= dst_reg_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit
    import mips_decode_pkg::*;
(
    instr_if.dec i_instr,
    ctrl_if.drv  o_ctrl
);

    logic       is_jr;
    logic       is_jalr;
    logic       is_unsigned;
    logic [1:0] mem_width;

    assign is_jr   = (i_instr.funct == FN_JR);
    assign is_jalr = (i_instr.funct == FN_JALR);

    // access size shared by loads and stores
    always_comb begin
        case (i_instr.opcode)
            OP_LB, OP_LBU, OP_SB: mem_width = WIDTH_BYTE;
            OP_LH, OP_LHU, OP_SH: mem_width = WIDTH_HALF;
            default:              mem_width = WIDTH_WORD;
        endcase
    end

    assign is_unsigned = (i_instr.opcode == OP_LBU) ||
                         (i_instr.opcode == OP_LHU) ||
                         (i_instr.opcode == OP_LWU);

    always_comb begin
        o_ctrl.jump       = 1'b0;
        o_ctrl.alu_src    = 1'b0;
        o_ctrl.alu_op     = ALUOP_ADD;
        o_ctrl.branch     = 1'b0;
        o_ctrl.reg_dst    = 1'b0;
        o_ctrl.link       = 1'b0;
        o_ctrl.mem_to_reg = 1'b0;
        o_ctrl.reg_write  = 1'b0;
        o_ctrl.mem_read   = 1'b0;
        o_ctrl.mem_write  = 1'b0;
        o_ctrl.width      = WIDTH_WORD;
        o_ctrl.sign_flag  = 1'b0;
        o_ctrl.zero_ext   = 1'b0;

        case (i_instr.opcode)
            OP_RTYPE: begin
                o_ctrl.reg_dst   = 1'b1;
                o_ctrl.alu_op    = ALUOP_RTYPE;
                o_ctrl.reg_write = ~is_jr;              // jr has no writeback
                o_ctrl.jump      = is_jr | is_jalr;
                o_ctrl.link      = is_jalr;             // return address into rd
            end

            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
                o_ctrl.alu_src    = 1'b1;               // base + offset
                o_ctrl.mem_to_reg = 1'b1;
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.mem_read   = 1'b1;
                o_ctrl.width      = mem_width;
                o_ctrl.sign_flag  = is_unsigned;
            end

            OP_SB, OP_SH, OP_SW: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.mem_write = 1'b1;
                o_ctrl.width     = mem_width;
            end

            OP_BEQ, OP_BNE: begin
                o_ctrl.branch = 1'b1;
                o_ctrl.alu_op = ALUOP_LOGIC;            // compare rs and rt
            end

            OP_ADDI: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end

            OP_ORI, OP_XORI: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.zero_ext  = 1'b1;                // logical ops take raw imm
                o_ctrl.alu_op    = ALUOP_LOGIC;
            end

            OP_SLTI: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = ALUOP_SLT;
            end

            OP_LUI: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.zero_ext  = 1'b1;
                o_ctrl.sign_flag = 1'b1;                // with zero_ext means shift by 16
            end

            OP_J: begin
                o_ctrl.jump = 1'b1;
            end

            OP_JAL: begin
                o_ctrl.jump      = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.link      = 1'b1;                // ra gets pc + 4
            end

            default: begin
                // unknown opcode keeps the defaults
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/apb_instr_port.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_instr_port
    import mips_decode_pkg::*;
(
    input  wire                clk,
    input  wire                i_rst_n,

    input  wire                i_psel,
    input  wire                i_penable,
    input  wire                i_pwrite,
    input  wire [ADDR_W-1:0]   i_paddr,
    input  wire [DATA_W-1:0]   i_pwdata,
    output logic [DATA_W-1:0]  o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,

    instr_if.src               o_instr
);

    logic   access;       // second cycle of a transfer
    logic   addr_hit;
    logic   wr_accept;
    logic   rd_accept;
    instr_u instr_q;
    logic   valid_q;

    assign access    = i_psel & i_penable;
    assign addr_hit  = (i_paddr == ADDR_INSTR);
    assign wr_accept = access & i_pwrite & addr_hit;
    assign rd_accept = access & ~i_pwrite & addr_hit;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            instr_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= wr_accept;                   // strobe follows the access phase
            if (wr_accept) begin
                instr_q <= i_pwdata;
            end
        end
    end

    // no wait states, so read data must be there during access
    assign o_prdata  = rd_accept ? instr_q : '0;
    assign o_pready  = 1'b1;
    assign o_pslverr = access & ~addr_hit;         // unmapped offset

    assign o_instr.valid  = valid_q;
    assign o_instr.instr  = instr_q;
    assign o_instr.opcode = instr_q.r_fmt.opcode;
    assign o_instr.funct  = instr_q.r_fmt.funct;

endmodule

`default_nettype wire

/* hdl/ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface ctrl_if ();

    logic       jump;
    logic       alu_src;        // 1 selects the immediate
    logic [1:0] alu_op;
    logic       branch;
    logic       reg_dst;        // 1 selects rd
    logic       link;           // write return address
    logic       mem_to_reg;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic [1:0] width;          // memory access size
    logic       sign_flag;      // unsigned load, or lui with zero_ext
    logic       zero_ext;       // immediate is not sign extended

    modport drv (
        output jump, alu_src, alu_op, branch, reg_dst, link,
        output mem_to_reg, reg_write, mem_read, mem_write,
        output width, sign_flag, zero_ext
    );

    modport snk (
        input jump, alu_src, alu_op, branch, reg_dst, link,
        input mem_to_reg, reg_write, mem_read, mem_write,
        input width, sign_flag, zero_ext
    );

endinterface

`default_nettype wire

/* hdl/instr_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface instr_if
    import mips_decode_pkg::*;
();

    logic             valid;    // one-cycle pulse per accepted write
    instr_u           instr;    // held until the next write
    logic [NB_OP-1:0] opcode;   // copies of the union fields
    logic [NB_OP-1:0] funct;

    modport src (
        output valid,
        output instr,
        output opcode,
        output funct
    );

    modport dec (
        input opcode,
        input funct
    );

    modport out (
        input valid,
        input instr
    );

endinterface

`default_nettype wire

/* hdl/mips_decode_pkg.sv */
`default_nettype none

package mips_decode_pkg;

    localparam int DATA_W = 32;     // instruction and apb data width
    localparam int NB_OP  = 6;      // opcode and funct fields
    localparam int NB_REG = 5;      // register number
    localparam int NB_IMM = 16;     // i-type immediate
    localparam int NB_TGT = 26;     // j-type target
    localparam int ADDR_W = 4;      // apb address width

    localparam logic [ADDR_W-1:0] ADDR_INSTR = 4'h0;   // instruction register offset

    // primary opcodes, bits [31:26]
    localparam logic [NB_OP-1:0] OP_RTYPE = 6'b000000;
    localparam logic [NB_OP-1:0] OP_J     = 6'b000010;
    localparam logic [NB_OP-1:0] OP_JAL   = 6'b000011;
    localparam logic [NB_OP-1:0] OP_BEQ   = 6'b000100;
    localparam logic [NB_OP-1:0] OP_BNE   = 6'b000101;
    localparam logic [NB_OP-1:0] OP_ADDI  = 6'b001000;
    localparam logic [NB_OP-1:0] OP_SLTI  = 6'b001010;
    localparam logic [NB_OP-1:0] OP_ORI   = 6'b001101;
    localparam logic [NB_OP-1:0] OP_XORI  = 6'b001110;
    localparam logic [NB_OP-1:0] OP_LUI   = 6'b001111;
    localparam logic [NB_OP-1:0] OP_LB    = 6'b100000;
    localparam logic [NB_OP-1:0] OP_LH    = 6'b100001;
    localparam logic [NB_OP-1:0] OP_LW    = 6'b100011;
    localparam logic [NB_OP-1:0] OP_LBU   = 6'b100100;
    localparam logic [NB_OP-1:0] OP_LHU   = 6'b100101;
    localparam logic [NB_OP-1:0] OP_LWU   = 6'b100111;
    localparam logic [NB_OP-1:0] OP_SB    = 6'b101000;
    localparam logic [NB_OP-1:0] OP_SH    = 6'b101001;
    localparam logic [NB_OP-1:0] OP_SW    = 6'b101011;

    // r-type funct codes that change control flow
    localparam logic [NB_OP-1:0] FN_JR   = 6'b001000;
    localparam logic [NB_OP-1:0] FN_JALR = 6'b001001;

    localparam logic [1:0] ALUOP_ADD   = 2'b00;
    localparam logic [1:0] ALUOP_LOGIC = 2'b01;    // also branch compare
    localparam logic [1:0] ALUOP_RTYPE = 2'b10;    // alu looks at funct
    localparam logic [1:0] ALUOP_SLT   = 2'b11;

    localparam logic [1:0] WIDTH_BYTE = 2'b00;
    localparam logic [1:0] WIDTH_HALF = 2'b01;
    localparam logic [1:0] WIDTH_WORD = 2'b11;

    localparam logic [NB_REG-1:0] RA_REG = 5'd31;  // jal link register

    typedef struct packed {
        logic [NB_OP-1:0]  opcode;
        logic [NB_REG-1:0] rs;
        logic [NB_REG-1:0] rt;
        logic [NB_REG-1:0] rd;
        logic [NB_REG-1:0] shamt;
        logic [NB_OP-1:0]  funct;
    } r_fmt_t;

    typedef struct packed {
        logic [NB_OP-1:0]  opcode;
        logic [NB_REG-1:0] rs;
        logic [NB_REG-1:0] rt;
        logic [NB_IMM-1:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [NB_OP-1:0]  opcode;
        logic [NB_TGT-1:0] target26;
    } j_fmt_t;

    // one 32-bit word, three views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

`default_nettype wire
